// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= camera_link_tb
FILELIST  ?= all.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := obj_dir/V$(TOP)
LOG     := sim.log

.PHONY: all run clean

all: $(BIN)

# rebuilt only when the file list or a source is newer than the binary
$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@! grep -q "TB FAILED" $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== all.f ====
rtl/uart_pkg.sv
rtl/camera_cmd_pkg.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/camera_serial_command_generator.sv
rtl/camera_link_top.sv
tb/camera_model.sv
tb/camera_link_tb.sv

// ==== rtl/camera_cmd_pkg.sv ====
package camera_cmd_pkg;
  import uart_pkg::*;

  // every command is six characters and the camera echoes all of them.
  localparam int cmd_len = 6;

  // indexes a command byte or counts reply bytes.
  typedef logic [2:0] cmd_idx_t;

  // "AMD N\r" first init step.
  localparam byte_t amd_cmd [cmd_len] = '{"A", "M", "D", " ", "N", "\r"};

  // "ACN 1\r" second init step.
  localparam byte_t acn_cmd [cmd_len] = '{"A", "C", "N", " ", "1", "\r"};

  localparam byte_t act_i_cmd [cmd_len] = '{"A", "C", "T", " ", "I", "\r"}; // take photo.

  localparam byte_t act_s_cmd [cmd_len] = '{"A", "C", "T", " ", "S", "\r"}; // stop photo.

  // each command has a send phase and an ack phase counting the echo.
  typedef enum logic [3:0] {
    idle,
    amd_send,
    amd_ack,
    acn_send,
    acn_ack,
    act_i_send,
    act_i_ack,
    act_s_send,
    act_s_ack
  } cmd_state_t;

endpackage

// ==== rtl/camera_link_top.sv ====
module camera_link_top
  import uart_pkg::*;
(
  input  logic sys_clk_50,
  input  logic rst,
  input  logic init_camera,
  input  logic take_photo,
  input  logic stop_photo,
  output logic busy,
  output logic camera_ready,
  output logic cam_txd,
  input  logic cam_rxd
);

  byte_t tx_data;
  byte_t rx_data;
  logic  tx_en;
  logic  tx_busy;
  logic  rx_done;

  camera_serial_command_generator camera_serial_command_generator_inst (
    .sys_clk_50   (sys_clk_50),
    .rst          (rst),
    .init_camera  (init_camera),
    .take_photo   (take_photo),
    .stop_photo   (stop_photo),
    .tx_data      (tx_data),
    .tx_en        (tx_en),
    .tx_busy      (tx_busy),
    .rx_data      (rx_data),
    .rx_done      (rx_done),
    .busy         (busy),
    .camera_ready (camera_ready)
  );

  uart_tx uart_tx_inst (
    .sys_clk_50 (sys_clk_50),
    .rst        (rst),
    .tx_data    (tx_data),
    .tx_en      (tx_en),
    .tx_busy    (tx_busy),
    .txd        (cam_txd)
  );

  // echo from the camera.
  uart_rx uart_rx_inst (
    .sys_clk_50 (sys_clk_50),
    .rst        (rst),
    .rxd        (cam_rxd),
    .rx_data    (rx_data),
    .rx_done    (rx_done)
  );

endmodule

// ==== rtl/camera_serial_command_generator.sv ====
module camera_serial_command_generator
  import uart_pkg::*, camera_cmd_pkg::*;
(
  input  logic  sys_clk_50,
  input  logic  rst,
  input  logic  init_camera,
  input  logic  take_photo,
  input  logic  stop_photo,
  output byte_t tx_data,
  output logic  tx_en,
  input  logic  tx_busy,
  input  byte_t rx_data, // reply content, not checked yet.
  input  logic  rx_done,
  output logic  busy,
  output logic  camera_ready
);

  cmd_state_t state;
  cmd_state_t state_next;
  cmd_state_t after_state;
  cmd_idx_t   idx;
  cmd_idx_t   idx_next;
  cmd_idx_t   reply_cnt;
  cmd_idx_t   reply_next;
  logic       ready_next;

  logic init_q;
  logic photo_q;
  logic stop_q;
  logic tx_busy_q;

  logic init_req;
  logic photo_req;
  logic stop_req;
  logic tx_rise;
  logic sending;
  logic waiting;
  logic last_byte;
  logic last_reply;

  assign init_req  = init_camera & ~init_q;
  assign photo_req = take_photo & ~photo_q;
  assign stop_req  = stop_photo & ~stop_q;
  assign tx_rise   = tx_busy & ~tx_busy_q; // uart_tx has latched the byte.

  assign last_byte  = (idx == cmd_idx_t'(cmd_len - 1));
  assign last_reply = (reply_cnt == cmd_idx_t'(cmd_len - 1));

  assign busy  = (state != idle);
  assign tx_en = sending;

  always_ff @(posedge sys_clk_50) begin
    if (rst) begin
      init_q    <= 1'b0;
      photo_q   <= 1'b0;
      stop_q    <= 1'b0;
      tx_busy_q <= 1'b0;
    end else begin
      init_q    <= init_camera;
      photo_q   <= take_photo;
      stop_q    <= stop_photo;
      tx_busy_q <= tx_busy;
    end
  end

  // per state, which table feeds the link and where the phase leads.
  always_comb begin
    sending     = 1'b0;
    waiting     = 1'b0;
    tx_data     = '0;
    after_state = idle;
    case (state)
      amd_send: begin
        sending     = 1'b1;
        tx_data     = amd_cmd[idx];
        after_state = amd_ack;
      end
      amd_ack: begin
        waiting     = 1'b1;
        after_state = acn_send; // second init step follows directly.
      end
      acn_send: begin
        sending     = 1'b1;
        tx_data     = acn_cmd[idx];
        after_state = acn_ack;
      end
      acn_ack: begin
        waiting = 1'b1;
      end
      act_i_send: begin
        sending     = 1'b1;
        tx_data     = act_i_cmd[idx];
        after_state = act_i_ack;
      end
      act_i_ack: begin
        waiting = 1'b1;
      end
      act_s_send: begin
        sending     = 1'b1;
        tx_data     = act_s_cmd[idx];
        after_state = act_s_ack;
      end
      act_s_ack: begin
        waiting = 1'b1;
      end
      default: begin
        sending = 1'b0;
      end
    endcase
  end

  always_comb begin
    state_next = state;
    idx_next   = idx;
    reply_next = reply_cnt;
    ready_next = camera_ready;
    if (state == idle) begin
      idx_next   = '0;
      reply_next = '0;
      // requests are only taken in idle, init has priority.
      if (init_req) begin
        state_next = amd_send;
      end else if (photo_req) begin
        state_next = act_i_send;
      end else if (stop_req) begin
        state_next = act_s_send;
      end
    end else begin
      // the camera echoes early bytes while later ones still go out.
      if (rx_done) begin
        reply_next = reply_cnt + 1'b1;
      end
      if (sending && tx_rise) begin
        if (last_byte) begin
          state_next = after_state;
          idx_next   = '0;
        end else begin
          idx_next = idx + 1'b1;
        end
      end
      if (waiting && rx_done && last_reply) begin
        state_next = after_state;
        reply_next = '0;
        if (state == acn_ack) begin
          ready_next = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge sys_clk_50) begin
    if (rst) begin
      state        <= idle;
      idx          <= '0;
      reply_cnt    <= '0;
      camera_ready <= 1'b0;
    end else begin
      state        <= state_next;
      idx          <= idx_next;
      reply_cnt    <= reply_next;
      camera_ready <= ready_next; // held until reset.
    end
  end

endmodule

// ==== rtl/uart_pkg.sv ====
package uart_pkg;

  // one character on the serial link.
  typedef logic [7:0] byte_t;

  // bit period in sys_clk_50 cycles, kept short so simulation stays fast.
  localparam int clks_per_bit = 16;

  localparam int data_bits = 8; // 8N1 framing.

  // counts the cycles inside one bit period.
  typedef logic [$clog2(clks_per_bit)-1:0] baud_cnt_t;

  // position inside a frame: start, data bits, stop.
  typedef logic [3:0] bit_idx_t;

endpackage

// ==== rtl/uart_rx.sv ====
module uart_rx
  import uart_pkg::*;
(
  input  logic  sys_clk_50,
  input  logic  rst,
  input  logic  rxd,
  output byte_t rx_data,
  output logic  rx_done
);

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_bits,
    rx_stop
  } rx_state_t;

  rx_state_t state;
  logic      rxd_meta;
  logic      rxd_sync;
  logic      rxd_prev;
  baud_cnt_t baud_cnt;
  bit_idx_t  bit_idx;
  byte_t     shift_reg;
  logic      half_bit;
  logic      full_bit;

  assign half_bit = (baud_cnt == baud_cnt_t'(clks_per_bit / 2 - 1));
  assign full_bit = (baud_cnt == baud_cnt_t'(clks_per_bit - 1));

  // two flop synchronizer plus one more stage for edge detection.
  always_ff @(posedge sys_clk_50) begin
    if (rst) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  always_ff @(posedge sys_clk_50) begin
    if (rst) begin
      state    <= rx_idle;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_done  <= 1'b0;
    end else begin
      rx_done  <= 1'b0;
      baud_cnt <= baud_cnt + 1'b1;
      case (state)
        rx_idle: begin
          baud_cnt <= '0;
          bit_idx  <= '0;
          if (rxd_prev && !rxd_sync) begin
            state <= rx_start;
          end
        end
        rx_start: begin
          if (half_bit) begin
            baud_cnt <= '0;
            // a glitch that is gone by mid-bit is not a start bit.
            state <= rxd_sync ? rx_idle : rx_bits;
          end
        end
        rx_bits: begin
          if (full_bit) begin
            baud_cnt <= '0;
            bit_idx  <= bit_idx + 1'b1;
            if (bit_idx == bit_idx_t'(data_bits - 1)) begin
              state <= rx_stop;
            end
          end
        end
        rx_stop: begin
          if (full_bit) begin
            rx_done <= rxd_sync; // framing error gives no pulse.
            state   <= rx_idle;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

  always_ff @(posedge sys_clk_50) begin
    if (state == rx_bits && full_bit) begin
      shift_reg <= {rxd_sync, shift_reg[7:1]};
    end
    if (state == rx_stop && full_bit && rxd_sync) begin
      rx_data <= shift_reg;
    end
  end

endmodule

// ==== rtl/uart_tx.sv ====
module uart_tx
  import uart_pkg::*;
(
  input  logic  sys_clk_50,
  input  logic  rst,
  input  byte_t tx_data,
  input  logic  tx_en,
  output logic  tx_busy,
  output logic  txd
);

  baud_cnt_t baud_cnt;
  bit_idx_t  bit_idx;
  byte_t     shift_reg;
  logic      bit_end;
  logic      frame_start;

  assign bit_end     = (baud_cnt == baud_cnt_t'(clks_per_bit - 1));
  assign frame_start = tx_en & ~tx_busy;

  // bit_idx 0 is the start bit, 1..8 the data bits and 9 the stop bit.
  always_ff @(posedge sys_clk_50) begin
    if (rst) begin
      tx_busy  <= 1'b0;
      txd      <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end else if (!tx_busy) begin
      baud_cnt <= '0;
      bit_idx  <= '0;
      if (tx_en) begin
        tx_busy <= 1'b1;
        txd     <= 1'b0; // start bit.
      end
    end else if (bit_end) begin
      baud_cnt <= '0;
      bit_idx  <= bit_idx + 1'b1;
      if (bit_idx == bit_idx_t'(data_bits + 1)) begin
        tx_busy <= 1'b0; // stop bit complete.
      end else if (bit_idx == bit_idx_t'(data_bits)) begin
        txd <= 1'b1;
      end else begin
        txd <= shift_reg[0];
      end
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // byte is captured at frame start so tx_data may move on mid-frame.
  always_ff @(posedge sys_clk_50) begin
    if (frame_start) begin
      shift_reg <= tx_data;
    end else if (tx_busy && bit_end && bit_idx < bit_idx_t'(data_bits)) begin
      shift_reg <= shift_reg >> 1; // lsb first.
    end
  end

endmodule

// ==== tb/camera_link_tb.sv ====
module camera_link_tb
  import uart_pkg::*, camera_cmd_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  // longest time one command may take, with generous slack for echo gaps.
  localparam int cmd_limit = 2 * cmd_len * 20 * clks_per_bit;
  localparam int quiet_cycles = 20 * clks_per_bit + 50;

  logic sys_clk_50;
  logic rst;
  logic init_camera;
  logic take_photo;
  logic stop_photo;
  logic busy;
  logic camera_ready;
  logic cam_txd;
  logic cam_rxd;

  camera_link_top camera_link_top_inst (
    .sys_clk_50   (sys_clk_50),
    .rst          (rst),
    .init_camera  (init_camera),
    .take_photo   (take_photo),
    .stop_photo   (stop_photo),
    .busy         (busy),
    .camera_ready (camera_ready),
    .cam_txd      (cam_txd),
    .cam_rxd      (cam_rxd)
  );

  camera_model camera_model_inst (
    .sys_clk_50 (sys_clk_50),
    .rxd        (cam_txd),
    .txd        (cam_rxd)
  );

  initial begin
    sys_clk_50 = 1'b0;
    forever #4 sys_clk_50 = ~sys_clk_50;
  end

  task automatic fail_now(input string reason);
    $display("TB FAILED");
    $display("%s", reason);
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("TB FAILED");
      $display("FAILED %s expected 0x%0h got 0x%0h", name, expected, actual);
      $fatal(1);
    end
  endtask

  task automatic apply_reset();
    @(negedge sys_clk_50);
    rst = 1'b1;
    repeat (16) @(negedge sys_clk_50);
    rst = 1'b0;
    @(negedge sys_clk_50);
    check_value("busy", 32'd0, 32'(busy));
    check_value("camera_ready", 32'd0, 32'(camera_ready));
    check_value("cam_txd", 32'd1, 32'(cam_txd));
  endtask

  // one cycle request pulse on any mix of the three inputs.
  task automatic pulse_requests(input logic init, input logic take, input logic stop);
    @(negedge sys_clk_50);
    init_camera = init;
    take_photo  = take;
    stop_photo  = stop;
    @(negedge sys_clk_50);
    init_camera = 1'b0;
    take_photo  = 1'b0;
    stop_photo  = 1'b0;
  endtask

  task automatic start_command(input logic init, input logic take, input logic stop);
    int cycles;
    cycles = 0;
    camera_model_inst.rx_log.delete();
    pulse_requests(init, take, stop);
    while (cam_txd !== 1'b0 && cycles < 3) begin
      @(negedge sys_clk_50);
      cycles++;
    end
    if (cam_txd !== 1'b0) fail_now("no start bit on cam_txd within 3 cycles of the request");
    check_value("busy", 32'd1, 32'(busy));
  endtask

  task automatic wait_idle(input int limit, input logic track_ready, input logic ready_level);
    int cycles;
    cycles = 0;
    while (busy && cycles < limit) begin
      @(negedge sys_clk_50);
      cycles++;
      if (track_ready) check_value("camera_ready", 32'(ready_level), 32'(camera_ready));
    end
    if (busy) fail_now("timeout while waiting for busy to fall");
  endtask

  task automatic wait_log_size(input int count, input int limit);
    int cycles;
    cycles = 0;
    while (camera_model_inst.rx_log.size() < count && cycles < limit) begin
      @(negedge sys_clk_50);
      cycles++;
    end
    if (camera_model_inst.rx_log.size() < count) fail_now("camera received too few bytes");
  endtask

  // idle window long enough for a stray frame to show up.
  task automatic watch_quiet(input int count);
    repeat (quiet_cycles) begin
      @(negedge sys_clk_50);
      check_value("busy", 32'd0, 32'(busy));
      check_value("camera byte count", 32'(count), 32'(camera_model_inst.rx_log.size()));
    end
  endtask

  task automatic check_table(input byte_t cmd_table [cmd_len]);
    cmd_idx_t k;
    k = '0;
    repeat (cmd_len) begin
      check_value("cam_txd byte", 32'(cmd_table[k]),
                  32'(camera_model_inst.rx_log.pop_front()));
      k++;
    end
  endtask

  initial begin
    rst         = 1'b1;
    init_camera = 1'b0;
    take_photo  = 1'b0;
    stop_photo  = 1'b0;
    apply_reset();

    start_command(1'b1, 1'b0, 1'b0);
    wait_idle(2 * cmd_limit, 1'b0, 1'b0);
    check_value("camera_ready", 32'd1, 32'(camera_ready));
    watch_quiet(2 * cmd_len);
    check_table(amd_cmd);
    check_table(acn_cmd);

    start_command(1'b0, 1'b1, 1'b0);
    wait_idle(cmd_limit, 1'b1, 1'b1);
    watch_quiet(cmd_len);
    check_table(act_i_cmd);

    start_command(1'b0, 1'b0, 1'b1);
    wait_idle(cmd_limit, 1'b1, 1'b1);
    watch_quiet(cmd_len);
    check_table(act_s_cmd);

    // take_photo during a running command must be dropped.
    start_command(1'b0, 1'b0, 1'b1);
    wait_log_size(2, cmd_limit);
    pulse_requests(1'b0, 1'b1, 1'b0);
    wait_idle(cmd_limit, 1'b1, 1'b1);
    watch_quiet(cmd_len);
    check_table(act_s_cmd);

    start_command(1'b0, 1'b1, 1'b1); // take_photo beats stop_photo.
    wait_idle(cmd_limit, 1'b1, 1'b1);
    watch_quiet(cmd_len);
    check_table(act_i_cmd);

    apply_reset();
    start_command(1'b0, 1'b1, 1'b0);
    wait_idle(cmd_limit, 1'b1, 1'b0);
    watch_quiet(cmd_len);
    check_value("camera_ready", 32'd0, 32'(camera_ready));
    check_table(act_i_cmd);

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== tb/camera_model.sv ====
module camera_model
  import uart_pkg::*;
(
  input  logic sys_clk_50,
  input  logic rxd, // host transmit line.
  output logic txd  // echo back to the host.
);
  timeunit 1ns;
  timeprecision 1ps;

  byte_t rx_log [$]; // host bytes in arrival order, read by the testbench.
  byte_t echo_q [$];

  task automatic wait_cycles(input int unsigned n);
    repeat (n) @(negedge sys_clk_50);
  endtask

  task automatic send_byte(input byte_t data);
    byte_t shift;
    shift = data;
    txd = 1'b0; // start bit.
    wait_cycles(clks_per_bit);
    repeat (data_bits) begin
      txd = shift[0];
      shift = shift >> 1;
      wait_cycles(clks_per_bit);
    end
    txd = 1'b1;
    wait_cycles(clks_per_bit);
  endtask

  // start bit seen half a clock in, so mid-bit lands about half a period later.
  initial begin : receive
    byte_t data;
    data = '0;
    forever begin
      @(negedge sys_clk_50);
      if (rxd === 1'b0) begin
        wait_cycles(clks_per_bit / 2);
        if (rxd === 1'b0) begin
          repeat (data_bits) begin
            wait_cycles(clks_per_bit);
            data = {rxd, data[7:1]}; // lsb arrives first.
          end
          wait_cycles(clks_per_bit);
          if (rxd === 1'b1) begin
            rx_log.push_back(data);
            echo_q.push_back(data);
          end
        end
      end
    end
  end

  initial begin : transmit
    byte_t       data;
    int unsigned gap;
    void'($urandom(12513));
    txd = 1'b1;
    forever begin
      @(negedge sys_clk_50);
      if (echo_q.size() != 0) begin
        data = echo_q.pop_front();
        gap  = $urandom % 41; // camera reply delay of 0 to 40 cycles.
        wait_cycles(gap);
        send_byte(data);
      end
    end
  end

endmodule
